// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_isa_pkg.sv
      - hdl/rv_pipe_pkg.sv
      - hdl/rv_fetch.sv
      - hdl/rv_id.sv
      - hdl/rv_regfile.sv
      - hdl/rv_ex.sv
      - hdl/rv_mem.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/rv_core_tb.sv

// ==== dv/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// instruction-level model, one call per retired instruction
logic [31:0] ref_regs [32];
logic [31:0] ref_dmem [DMEM_WORDS];
logic [31:0] ref_pc;

function automatic logic [31:0] alu_calc(
  input logic [2:0]  f3,
  input logic        alt,
  input logic [31:0] a,
  input logic [31:0] b
);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic cond_met(input logic [2:0] f3, input logic [31:0] a,
                                  input logic [31:0] b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic int word_index(input logic [31:0] addr);
  return (addr >> 2) % DMEM_WORDS;  // wraps like the data memory
endfunction

function automatic void step_model(input logic [31:0] w, output logic wb,
                                   output logic [4:0] rd, output logic [31:0] data);
  logic [6:0]  op;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] next_pc;
  op      = w[6:0];
  rd      = w[11:7];
  f3      = w[14:12];
  f7      = w[31:25];
  a       = ref_regs[w[19:15]];
  b       = ref_regs[w[24:20]];
  imm_i   = {{20{w[31]}}, w[31:20]};
  imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
  imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  wb      = 1'b0;
  data    = '0;
  next_pc = ref_pc + 32'd4;
  case (op)
    rv_isa_pkg::OP_LUI: begin
      wb   = 1'b1;
      data = {w[31:12], 12'b0};
    end
    rv_isa_pkg::OP_AUIPC: begin
      wb   = 1'b1;
      data = ref_pc + {w[31:12], 12'b0};
    end
    rv_isa_pkg::OP_JAL: begin
      wb      = 1'b1;
      data    = ref_pc + 32'd4;
      next_pc = ref_pc + imm_j;
    end
    rv_isa_pkg::OP_JALR: begin
      wb      = 1'b1;
      data    = ref_pc + 32'd4;
      next_pc = (a + imm_i) & ~32'd1;
    end
    rv_isa_pkg::OP_BRANCH: if (cond_met(f3, a, b)) next_pc = ref_pc + imm_b;
    rv_isa_pkg::OP_LOAD: begin
      wb   = 1'b1;
      data = ref_dmem[word_index(a + imm_i)];
    end
    rv_isa_pkg::OP_STORE:  ref_dmem[word_index(a + imm_s)] = b;
    rv_isa_pkg::OP_ARITHI: begin
      wb   = 1'b1;
      data = alu_calc(f3, (f3 == 3'd5) && f7[5], a, imm_i);
    end
    rv_isa_pkg::OP_ARITHR: if (!f7[0]) begin  // mul encodings do nothing
      wb   = 1'b1;
      data = alu_calc(f3, f7[5], a, b);
    end
    default: ;  // fence, system
  endcase
  wb = wb && (rd != 5'd0);
  if (wb) ref_regs[rd] = data;
  ref_pc = next_pc;
endfunction

`endif

// ==== dv/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          DMEM_WORDS = 256;
  localparam int          PROG_WORDS = 1024;
  localparam int          WB_TIMEOUT = 200;  // cycles per writeback
  localparam int          QUIET      = 60;
  localparam logic [31:0] NOP        = 32'h0000_0013;

  typedef struct {
    logic [4:0]  rd;
    logic [31:0] data;
    string       name;
  } wb_exp_t;

  logic        clk_i   = 1'b0;
  logic        reset_i = 1'b1;
  logic [31:0] imem_addr_o;
  logic [31:0] imem_data_i = NOP;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;

  logic [31:0] prog [PROG_WORDS];
  string       tags [PROG_WORDS];
  int          n;
  int          end_word;
  logic [11:0] stored [$];
  wb_exp_t     exp_q [$];

  `include "rv_ref_model.svh"

  rv_core #(.RESET_PC(32'h0), .DMEM_WORDS(DMEM_WORDS)) uut (
    .clk_i, .reset_i, .imem_addr_o, .imem_data_i, .wb_valid_o, .wb_rd_o, .wb_data_o
  );

  always #50 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if ($isunknown(imem_addr_o) || imem_addr_o >= PROG_WORDS * 4) imem_data_i <= NOP;
    else imem_data_i <= prog[imem_addr_o[31:2]];
  end

  function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_ARITHR};
  endfunction

  function automatic logic [31:0] btype(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] jtype(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
  endfunction

  function automatic logic [31:0] stype(logic [11:0] imm, logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv_isa_pkg::OP_STORE};
  endfunction

  function automatic logic [4:0] any_reg();
    return 5'($urandom_range(0, 15));  // x1..x15 hold values
  endfunction

  function automatic logic [4:0] live_reg();
    return 5'($urandom_range(1, 15));
  endfunction

  function automatic logic [4:0] dest_reg();
    return ($urandom_range(0, 7) == 0) ? 5'd0 : live_reg();
  endfunction

  function automatic logic [31:0] rand_alu();
    logic [2:0] f3;
    logic       alt;
    f3  = 3'($urandom_range(0, 7));
    alt = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1);
    if ($urandom_range(0, 1) == 1) return rtype(alt ? 7'h20 : 7'h00, any_reg(), any_reg(), f3,
                                                dest_reg());
    if (f3 == 3'd1 || f3 == 3'd5)
      return itype({(alt && f3 == 3'd5) ? 7'h20 : 7'h00, 5'($urandom)}, any_reg(), f3,
                   dest_reg(), rv_isa_pkg::OP_ARITHI);
    return itype(12'($urandom), any_reg(), f3, dest_reg(), rv_isa_pkg::OP_ARITHI);
  endfunction

  task automatic emit(input logic [31:0] w, input string tag);
    prog[n] = w;
    tags[n] = tag;
    n++;
  endtask

  task automatic build_program();
    logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [11:0] off;
    logic [4:0]  r;
    logic [4:0]  s;
    foreach (prog[i]) prog[i] = NOP;
    n = 0;
    for (int i = 1; i < 16; i++)
      emit(itype(12'($urandom), 5'd0, 3'd0, 5'(i), rv_isa_pkg::OP_ARITHI), "init");
    while (n < 480) begin
      case ($urandom_range(0, 9))
        3: emit({20'($urandom), dest_reg(), ($urandom_range(0, 1) == 1) ?
                 rv_isa_pkg::OP_LUI : rv_isa_pkg::OP_AUIPC}, "lui_auipc");
        4: begin
          off = {10'($urandom), 2'b00};
          stored.push_back(off);
          r = live_reg();
          emit(stype(off, any_reg()), "store");
          emit(itype(stored[$urandom_range(0, stored.size() - 1)], 5'd0, 3'b010, r,
                     rv_isa_pkg::OP_LOAD), "load_use");
          emit(rtype(7'h00, any_reg(), r, 3'd0, live_reg()), "load_use");
        end
        5: begin
          r = live_reg();
          s = ($urandom_range(0, 3) == 0) ? r : any_reg();
          emit(btype(13'd12, s, r, br_f3[$urandom_range(0, 5)]), "branch");
          emit(rand_alu(), "branch_slot");
          emit(rand_alu(), "branch_fall");
        end
        6: begin
          emit(jtype(21'd12, dest_reg()), "jal");
          emit(rand_alu(), "jal_slot");
          emit(rand_alu(), "jal_skip");
        end
        7: begin
          r   = live_reg();
          s   = live_reg();
          off = {10'($urandom), 2'b00};
          emit(itype(12'((n + 6) * 4), 5'd0, 3'd0, r, rv_isa_pkg::OP_ARITHI), "jalr_load");
          emit(stype(off, r), "jalr_load");
          emit(itype(off, 5'd0, 3'b010, s, rv_isa_pkg::OP_LOAD), "jalr_load");
          emit(itype(12'd0, s, 3'd0, dest_reg(), rv_isa_pkg::OP_JALR), "jalr_load");
          emit(rand_alu(), "jalr_slot");
          emit(rand_alu(), "jalr_skip");
        end
        8: case ($urandom_range(0, 3))
          0: emit(32'h0000_000f, "fence");
          1: emit(32'h0000_0073, "system");
          2: emit(rtype(7'h01, any_reg(), any_reg(), 3'd0, live_reg()), "mul");
          default: emit(rtype(7'h00, any_reg(), any_reg(), 3'd0, 5'd0), "x0_write");
        endcase
        default: emit(rand_alu(), "alu");
      endcase
    end
    end_word = n;
    emit(jtype(21'd0, 5'd0), "end_loop");
    emit(rand_alu(), "end_slot");
  endtask

  initial begin
    logic        wb;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] step_pc;
    int          steps;
    void'($urandom(48));
    build_program();
    ref_regs = '{default: 32'd0};
    ref_pc   = 32'd0;
    steps    = 0;
    while (ref_pc != end_word * 4 && steps < 5000) begin
      step_pc = ref_pc;
      step_model(prog[step_pc[31:2]], wb, rd, data);
      if (wb) exp_q.push_back('{rd, data, tags[step_pc[31:2]]});
      steps++;
    end
    reset_i = 1'b1;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
  end

  // compare process
  initial begin
    wb_exp_t e;
    int      cycles;
    cycles = 0;
    while (reset_i && cycles < 100) begin
      @(negedge clk_i);
      cycles++;
    end
    while (exp_q.size() > 0) begin
      e      = exp_q.pop_front();
      cycles = 0;
      do begin
        @(negedge clk_i);
        cycles++;
      end while (!wb_valid_o && cycles < WB_TIMEOUT);
      assert (wb_valid_o) else begin
        $display("timeout waiting for a writeback of %s", e.name);
        $display("tests failed");
        $fatal(1);
      end
      assert (wb_rd_o == e.rd) else begin
        $display("** Error %s: expected rd %0d, actual rd %0d", e.name, e.rd, wb_rd_o);
        $display("tests failed");
        $fatal(1);
      end
      assert (wb_data_o == e.data) else begin
        $display("** Error %s: expected %h, actual %h", e.name, e.data, wb_data_o);
        $display("tests failed");
        $fatal(1);
      end
    end
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!wb_valid_o && cycles < QUIET);
    if (wb_valid_o) begin
      $display("unexpected extra writeback to x%0d", wb_rd_o);
      $display("tests failed");
      $fatal(1);
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`default_nettype none

module rv_core #(
  parameter logic [31:0] RESET_PC   = 32'h0,
  parameter int          DMEM_WORDS = 256
) (
  input  logic        clk_i,
  input  logic        reset_i,
  output logic [31:0] imem_addr_o,
  input  logic [31:0] imem_data_i,
  output logic        wb_valid_o,
  output logic [4:0]  wb_rd_o,
  output logic [31:0] wb_data_o
);

  rv_pipe_pkg::if_id_t  if_id;
  rv_pipe_pkg::id_ex_t  id_ex;
  rv_pipe_pkg::ex_mem_t ex_mem;
  rv_pipe_pkg::mem_wb_t mem_wb;
  rv_pipe_pkg::fwd_t    ex_fwd;
  rv_pipe_pkg::fwd_t    mem_fwd;
  logic                 stall;
  logic                 branch_taken;
  logic [31:0]          branch_target;
  logic                 rs1_read;
  logic                 rs2_read;
  logic [4:0]           rs1_addr;
  logic [4:0]           rs2_addr;
  logic [31:0]          rs1_data;
  logic [31:0]          rs2_data;

  rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
    .clk_i, .reset_i, .stall_i(stall),
    .branch_taken_i(branch_taken), .branch_target_i(branch_target),
    .imem_addr_o, .imem_data_i, .if_id_o(if_id)
  );

  rv_id u_id (
    .clk_i, .reset_i, .if_id_i(if_id),
    .rs1_read_o(rs1_read), .rs2_read_o(rs2_read),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd), .id_ex_o(id_ex),
    .branch_taken_o(branch_taken), .branch_target_o(branch_target), .stall_o(stall)
  );

  rv_regfile u_regfile (
    .clk_i, .reset_i,
    .rs1_read_i(rs1_read), .rs2_read_i(rs2_read),
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .wb_i(mem_wb)
  );

  rv_ex u_ex (
    .clk_i, .reset_i, .stall_i(stall),
    .id_ex_i(id_ex), .ex_mem_o(ex_mem), .ex_fwd_o(ex_fwd)
  );

  rv_mem #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
    .clk_i, .reset_i, .ex_mem_i(ex_mem), .mem_wb_o(mem_wb), .mem_fwd_o(mem_fwd)
  );

  assign wb_valid_o = mem_wb.wreg && (mem_wb.rd != 5'd0);  // x0 writes are dropped
  assign wb_rd_o    = mem_wb.rd;
  assign wb_data_o  = mem_wb.data;

endmodule

`default_nettype wire

// ==== hdl/rv_ex.sv ====
`default_nettype none

module rv_ex (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 stall_i,
  input  rv_pipe_pkg::id_ex_t  id_ex_i,
  output rv_pipe_pkg::ex_mem_t ex_mem_o,
  output rv_pipe_pkg::fwd_t    ex_fwd_o
);

  rv_pipe_pkg::id_ex_t q;
  logic [31:0]         op_a;
  logic [31:0]         op_b;
  logic [31:0]         result;

  always_ff @(posedge clk_i) begin
    q <= id_ex_i;
    if (reset_i || stall_i) begin  // bubble
      q.wreg    <= 1'b0;
      q.memrd   <= 1'b0;
      q.memwr   <= 1'b0;
      q.mem2reg <= 1'b0;
    end
  end

  // pc is recovered from the link address
  assign op_a = (q.src1 == rv_isa_pkg::SRC1_PC) ? q.link_addr - 32'd4 : q.rs1_data;
  assign op_b = (q.src2 == rv_isa_pkg::SRC2_IMM) ? q.imm : q.rs2_data;

  always_comb begin
    case (1'b1)
      q.aluop[rv_isa_pkg::ALU_ADD]:  result = op_a + op_b;
      q.aluop[rv_isa_pkg::ALU_SUB]:  result = op_a - op_b;
      q.aluop[rv_isa_pkg::ALU_SLL]:  result = op_a << op_b[4:0];
      q.aluop[rv_isa_pkg::ALU_SLT]:  result = {31'b0, $signed(op_a) < $signed(op_b)};
      q.aluop[rv_isa_pkg::ALU_SLTU]: result = {31'b0, op_a < op_b};
      q.aluop[rv_isa_pkg::ALU_XOR]:  result = op_a ^ op_b;
      q.aluop[rv_isa_pkg::ALU_SRL]:  result = op_a >> op_b[4:0];
      q.aluop[rv_isa_pkg::ALU_SRA]:  result = $signed(op_a) >>> op_b[4:0];
      q.aluop[rv_isa_pkg::ALU_OR]:   result = op_a | op_b;
      q.aluop[rv_isa_pkg::ALU_AND]:  result = op_a & op_b;
      q.aluop[rv_isa_pkg::ALU_LINK]: result = q.link_addr;
      default:                       result = '0;
    endcase
  end

  always_comb begin
    ex_mem_o.alu_result = result;
    ex_mem_o.store_data = q.rs2_data;
    ex_mem_o.rd         = q.rd;
    ex_mem_o.wreg       = q.wreg;
    ex_mem_o.memrd      = q.memrd;
    ex_mem_o.memwr      = q.memwr;
  end

  always_comb begin
    ex_fwd_o.wreg  = q.wreg;
    ex_fwd_o.rd    = q.rd;
    ex_fwd_o.data  = result;
    ex_fwd_o.memrd = q.mem2reg;  // a load result is not here yet
  end

endmodule

`default_nettype wire

// ==== hdl/rv_fetch.sv ====
`default_nettype none

module rv_fetch #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                stall_i,
  input  logic                branch_taken_i,
  input  logic [31:0]         branch_target_i,
  output logic [31:0]         imem_addr_o,
  input  logic [31:0]         imem_data_i,
  output rv_pipe_pkg::if_id_t if_id_o
);

  logic [31:0] pc;

  assign imem_addr_o = pc;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc                   <= RESET_PC;
      if_id_o.in_delayslot <= 1'b1;  // decode sees a bubble
    end else if (!stall_i) begin
      pc                   <= branch_taken_i ? branch_target_i : pc + 32'd4;
      if_id_o.pc           <= pc;
      if_id_o.inst         <= imem_data_i;
      // the word fetched alongside a taken branch is the delay slot
      if_id_o.in_delayslot <= branch_taken_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_id.sv ====
`default_nettype none

module rv_id (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  rv_pipe_pkg::if_id_t  if_id_i,
  output logic                 rs1_read_o,
  output logic                 rs2_read_o,
  output logic [4:0]           rs1_addr_o,
  output logic [4:0]           rs2_addr_o,
  input  logic [31:0]          rs1_data_i,
  input  logic [31:0]          rs2_data_i,
  input  rv_pipe_pkg::fwd_t    ex_fwd_i,
  input  rv_pipe_pkg::fwd_t    mem_fwd_i,
  output rv_pipe_pkg::id_ex_t  id_ex_o,
  output logic                 branch_taken_o,
  output logic [31:0]          branch_target_o,
  output logic                 stall_o
);

  rv_isa_pkg::inst_u   inst;
  rv_pipe_pkg::id_ex_t dec;
  logic                valid;
  logic                taken;
  logic [31:0]         rs1_val;
  logic [31:0]         rs2_val;
  logic [31:0]         imm_i;
  logic [31:0]         imm_s;
  logic [31:0]         imm_b;
  logic [31:0]         imm_u;
  logic [31:0]         imm_j;

  function automatic logic [rv_isa_pkg::ALU_OP_W-1:0] alu_onehot(
    input logic [2:0] f3,
    input logic       sub,
    input logic       sra
  );
    logic [rv_isa_pkg::ALU_OP_W-1:0] w;
    w = '0;
    case (f3)
      rv_isa_pkg::F3_ADD:  w[sub ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD] = 1'b1;
      rv_isa_pkg::F3_SLL:  w[rv_isa_pkg::ALU_SLL] = 1'b1;
      rv_isa_pkg::F3_SLT:  w[rv_isa_pkg::ALU_SLT] = 1'b1;
      rv_isa_pkg::F3_SLTU: w[rv_isa_pkg::ALU_SLTU] = 1'b1;
      rv_isa_pkg::F3_XOR:  w[rv_isa_pkg::ALU_XOR] = 1'b1;
      rv_isa_pkg::F3_SR:   w[sra ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL] = 1'b1;
      rv_isa_pkg::F3_OR:   w[rv_isa_pkg::ALU_OR] = 1'b1;
      default:             w[rv_isa_pkg::ALU_AND] = 1'b1;
    endcase
    return w;
  endfunction

  // does a later stage write the register this port reads
  function automatic logic hit(
    input rv_pipe_pkg::fwd_t f,
    input logic              rd_en,
    input logic [4:0]        addr
  );
    return rd_en && f.wreg && (f.rd != 5'd0) && (f.rd == addr);
  endfunction

  assign inst  = if_id_i.inst;
  assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_b = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                  inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
  assign imm_u = {inst.u_fmt.imm, 12'b0};
  assign imm_j = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                  inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

  always_comb begin
    dec                        = '0;
    dec.aluop[rv_isa_pkg::ALU_ADD] = 1'b1;
    dec.src1                   = rv_isa_pkg::SRC1_REG;
    dec.src2                   = rv_isa_pkg::SRC2_REG;
    dec.link_addr              = if_id_i.pc + 32'd4;
    dec.rd                     = inst.r_fmt.rd;
    rs1_read_o                 = 1'b0;
    rs2_read_o                 = 1'b0;
    rs1_addr_o                 = inst.r_fmt.rs1;
    rs2_addr_o                 = inst.r_fmt.rs2;
    valid                      = 1'b0;
    if (!if_id_i.in_delayslot) begin
      case (inst.r_fmt.opcode)
        rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
          dec.src1 = (inst.u_fmt.opcode == rv_isa_pkg::OP_AUIPC) ? rv_isa_pkg::SRC1_PC
                                                                 : rv_isa_pkg::SRC1_REG;
          dec.src2 = rv_isa_pkg::SRC2_IMM;
          dec.imm  = imm_u;
          dec.wreg = 1'b1;
          valid    = 1'b1;
        end
        rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
          dec.aluop  = '0;
          dec.aluop[rv_isa_pkg::ALU_LINK] = 1'b1;
          dec.wreg   = 1'b1;
          rs1_read_o = (inst.i_fmt.opcode == rv_isa_pkg::OP_JALR);
          valid      = 1'b1;
        end
        rv_isa_pkg::OP_BRANCH: begin
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
          valid      = (inst.b_fmt.funct3[2:1] != 2'b01);  // 010/011 undefined
        end
        rv_isa_pkg::OP_LOAD: begin
          dec.src2    = rv_isa_pkg::SRC2_IMM;
          dec.imm     = imm_i;
          dec.wreg    = 1'b1;
          dec.memrd   = 1'b1;
          dec.mem2reg = 1'b1;
          rs1_read_o  = 1'b1;
          valid       = 1'b1;
        end
        rv_isa_pkg::OP_STORE: begin
          dec.src2   = rv_isa_pkg::SRC2_IMM;
          dec.imm    = imm_s;
          dec.memwr  = 1'b1;
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
          valid      = 1'b1;
        end
        rv_isa_pkg::OP_ARITHI: begin
          dec.aluop  = alu_onehot(inst.i_fmt.funct3, 1'b0, inst.r_fmt.funct7[5]);
          dec.src2   = rv_isa_pkg::SRC2_IMM;
          dec.imm    = imm_i;
          dec.wreg   = 1'b1;
          rs1_read_o = 1'b1;
          valid      = 1'b1;
        end
        rv_isa_pkg::OP_ARITHR: begin
          dec.aluop  = alu_onehot(inst.r_fmt.funct3, inst.r_fmt.funct7[5],
                                  inst.r_fmt.funct7[5]);
          dec.wreg   = 1'b1;
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
          valid      = !inst.r_fmt.funct7[0];  // no M extension
        end
        rv_isa_pkg::OP_FENCE, rv_isa_pkg::OP_SYSTEM: valid = 1'b1;
        default: valid = 1'b0;
      endcase
    end
  end

  // EX first, then MEM, then regfile (which covers WB)
  assign rs1_val = hit(ex_fwd_i, rs1_read_o, rs1_addr_o)  ? ex_fwd_i.data  :
                   hit(mem_fwd_i, rs1_read_o, rs1_addr_o) ? mem_fwd_i.data : rs1_data_i;
  assign rs2_val = hit(ex_fwd_i, rs2_read_o, rs2_addr_o)  ? ex_fwd_i.data  :
                   hit(mem_fwd_i, rs2_read_o, rs2_addr_o) ? mem_fwd_i.data : rs2_data_i;

  assign stall_o = (hit(ex_fwd_i, rs1_read_o, rs1_addr_o) && ex_fwd_i.memrd)
                || (hit(mem_fwd_i, rs1_read_o, rs1_addr_o) && mem_fwd_i.memrd)
                || (hit(ex_fwd_i, rs2_read_o, rs2_addr_o) && ex_fwd_i.memrd)
                || (hit(mem_fwd_i, rs2_read_o, rs2_addr_o) && mem_fwd_i.memrd);

  always_comb begin
    taken           = 1'b0;
    branch_target_o = if_id_i.pc + imm_b;
    if (valid) begin
      case (inst.r_fmt.opcode)
        rv_isa_pkg::OP_JAL: begin
          taken           = 1'b1;
          branch_target_o = if_id_i.pc + imm_j;
        end
        rv_isa_pkg::OP_JALR: begin
          taken           = 1'b1;
          branch_target_o = (rs1_val + imm_i) & ~32'd1;
        end
        rv_isa_pkg::OP_BRANCH: begin
          case (inst.b_fmt.funct3)
            rv_isa_pkg::F3_BEQ:  taken = (rs1_val == rs2_val);
            rv_isa_pkg::F3_BNE:  taken = (rs1_val != rs2_val);
            rv_isa_pkg::F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            rv_isa_pkg::F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            rv_isa_pkg::F3_BLTU: taken = (rs1_val < rs2_val);
            rv_isa_pkg::F3_BGEU: taken = (rs1_val >= rs2_val);
            default:             taken = 1'b0;
          endcase
        end
        default: taken = 1'b0;
      endcase
    end
  end

  assign branch_taken_o = taken && !stall_o;  // operands may be stale

  always_comb begin
    id_ex_o          = dec;
    id_ex_o.rs1_data = rs1_val;
    id_ex_o.rs2_data = rs2_val;
    if (!valid || stall_o) begin
      id_ex_o.wreg    = 1'b0;
      id_ex_o.memrd   = 1'b0;
      id_ex_o.memwr   = 1'b0;
      id_ex_o.mem2reg = 1'b0;
    end
  end

  a_aluop_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot(id_ex_o.aluop));

  // a stalled fetch would hold and leave the slot unmarked
  a_no_redirect_in_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    branch_taken_o |=> if_id_i.in_delayslot);

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_ARITHI = 7'b0010011,
    OP_ARITHR = 7'b0110011,
    OP_FENCE  = 7'b0001111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // branch func3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // arithmetic func3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // bit positions in the one-hot alu word
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LINK
  } alu_op_e;

  localparam int ALU_OP_W = 11;

  typedef enum logic {SRC1_REG, SRC1_PC} src1_e;
  typedef enum logic {SRC2_REG, SRC2_IMM} src2_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

endpackage

`default_nettype wire

// ==== hdl/rv_mem.sv ====
`default_nettype none

module rv_mem #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  rv_pipe_pkg::ex_mem_t ex_mem_i,
  output rv_pipe_pkg::mem_wb_t mem_wb_o,
  output rv_pipe_pkg::fwd_t    mem_fwd_o
);

  localparam int AW = $clog2(DMEM_WORDS);

  rv_pipe_pkg::ex_mem_t q;
  logic [31:0]          dmem [DMEM_WORDS];
  logic [AW-1:0]        idx;
  logic [31:0]          wb_data;

  if (DMEM_WORDS != (1 << AW)) begin : g_size_check
    $error("DMEM_WORDS must be a power of two");
  end

  always_ff @(posedge clk_i) begin
    q <= ex_mem_i;
    if (reset_i) begin
      q.wreg  <= 1'b0;
      q.memrd <= 1'b0;
      q.memwr <= 1'b0;
    end
  end

  assign idx     = q.alu_result[AW+1:2];  // word address wraps
  assign wb_data = q.memrd ? dmem[idx] : q.alu_result;

  always_ff @(posedge clk_i) begin
    if (q.memwr) dmem[idx] <= q.store_data;
  end

  always_ff @(posedge clk_i) begin
    mem_wb_o.data <= wb_data;
    mem_wb_o.rd   <= q.rd;
    mem_wb_o.wreg <= reset_i ? 1'b0 : q.wreg;
  end

  always_comb begin
    mem_fwd_o.wreg  = q.wreg;
    mem_fwd_o.rd    = q.rd;
    mem_fwd_o.data  = wb_data;
    mem_fwd_o.memrd = q.memrd;
  end

  a_rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(q.memrd && q.memwr));

endmodule

`default_nettype wire

// ==== hdl/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

  typedef struct packed {
    logic [31:0]       pc;
    rv_isa_pkg::inst_u inst;
    logic              in_delayslot;
  } if_id_t;

  typedef struct packed {
    logic [rv_isa_pkg::ALU_OP_W-1:0] aluop;
    rv_isa_pkg::src1_e               src1;
    rv_isa_pkg::src2_e               src2;
    logic [31:0]                     imm;
    logic [31:0]                     rs1_data;
    logic [31:0]                     rs2_data;
    logic [31:0]                     link_addr;  // pc+4 of the instruction
    logic [4:0]                      rd;
    logic                            wreg;
    logic                            memrd;
    logic                            memwr;
    logic                            mem2reg;
  } id_ex_t;

  typedef struct packed {
    logic [31:0] alu_result;
    logic [31:0] store_data;
    logic [4:0]  rd;
    logic        wreg;
    logic        memrd;
    logic        memwr;
  } ex_mem_t;

  typedef struct packed {
    logic [31:0] data;
    logic [4:0]  rd;
    logic        wreg;
  } mem_wb_t;

  // sent back to decode from EX and MEM
  typedef struct packed {
    logic        wreg;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        memrd;  // value not ready, load still in flight
  } fwd_t;

endpackage

`default_nettype wire

// ==== hdl/rv_regfile.sv ====
`default_nettype none

module rv_regfile (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 rs1_read_i,
  input  logic                 rs2_read_i,
  input  logic [4:0]           rs1_addr_i,
  input  logic [4:0]           rs2_addr_i,
  output logic [31:0]          rs1_data_o,
  output logic [31:0]          rs2_data_o,
  input  rv_pipe_pkg::mem_wb_t wb_i
);

  logic [31:0] regs [32];  // entry 0 never written

  function automatic logic [31:0] read_port(input logic en, input logic [4:0] addr);
    if (!en || addr == 5'd0) return '0;
    if (wb_i.wreg && wb_i.rd == addr) return wb_i.data;  // write-through
    return regs[addr];
  endfunction

  always_ff @(posedge clk_i) begin
    if (wb_i.wreg && wb_i.rd != 5'd0) regs[wb_i.rd] <= wb_i.data;
  end

  always_comb rs1_data_o = read_port(rs1_read_i, rs1_addr_i);
  always_comb rs2_data_o = read_port(rs2_read_i, rs2_addr_i);

  a_x0_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    (rs1_read_i && rs1_addr_i == 5'd0) |-> (rs1_data_o == 32'd0));

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+dv
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_fetch.sv
hdl/rv_id.sv
hdl/rv_regfile.sv
hdl/rv_ex.sv
hdl/rv_mem.sv
hdl/rv_core.sv
dv/rv_core_tb.sv
